// File: rv_mike.f
+incdir+common
common/rv_mike_pkg.sv
common/exec_ctrl_if.sv
rtl/core/alu.sv
rtl/core/reg_file.sv
rtl/retire_counter.sv
rtl/core/instr_decoder.sv
rtl/core/exec_fsm.sv
rtl/core/rv_mike_core.sv
sim/tb_rv_mike.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_rv_mike
FILELIST  = rv_mike.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "ALL CHECKS PASSED"

clean:
	rm -rf $(OBJ_DIR)

// File: sim/tb_rv_mike.sv
`include "rv_mike_macros.svh"

module tb_rv_mike;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 16;
    localparam int SAMPLE_DELAY = 2;   // after the falling edge, well before the rising edge
    localparam int MAX_WAIT     = 16;
    localparam int NUM_UPPER    = 40;
    localparam int NUM_ALU      = 200;
    localparam int NUM_BRANCH   = 60;
    localparam int NUM_ILLEGAL  = 40;
    // every transfer of the run, instruction writes and reads alike
    localparam int NUM_XFERS    = 3 + 3 * NUM_UPPER + NUM_ALU + 2 * NUM_BRANCH
                                  + 2 * NUM_ILLEGAL + 2 * 32 + 3;
    localparam int WATCHDOG_NS  = (NUM_XFERS * 10 + RESET_CYCLES + 200) * CLK_PERIOD;
    localparam logic [31:0] LFSR_SEED = 32'hf5b2_03fb;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic                  clk;
    logic                  rst_n;
    logic [`RV_APB_AW-1:0] paddr;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [`RV_XLEN-1:0]   pwdata;
    logic [`RV_XLEN-1:0]   prdata;
    logic                  pready;
    logic                  pslverr;

    logic [31:0]         lfsr_state;
    logic [`RV_XLEN-1:0] m_regs [32];  // reference model state
    logic [`RV_XLEN-1:0] m_pc;
    logic [15:0]         m_retired;
    logic [15:0]         m_taken;
    logic [15:0]         n_legal;
    int reg_errors;
    int pc_errors;
    int count_errors;
    int resp_errors;
    int handshake_errors;

    rv_mike_core uut (
        .clk     (clk),
        .rst_n   (rst_n),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("CHECKS FAILED");
        $finish;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    // one LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    task automatic check_reg(input int idx, input logic [`RV_XLEN-1:0] got,
                             input logic [`RV_XLEN-1:0] exp);
        if (got !== exp) begin
            reg_errors++;
            $display("error: x%0d got %h expected %h", idx, got, exp);
        end
    endtask

    task automatic check_pc(input logic [`RV_XLEN-1:0] got, input logic [`RV_XLEN-1:0] exp);
        if (got !== exp) begin
            pc_errors++;
            $display("error: pc got %h expected %h", got, exp);
        end
    endtask

    task automatic check_count(input logic [`RV_XLEN-1:0] got,
                               input logic [`RV_XLEN-1:0] exp);
        if (got !== exp) begin
            count_errors++;
            $display("error: retired_count got %h expected %h", got, exp);
        end
    endtask

    task automatic check_resp(input logic [`RV_APB_AW-1:0] addr, input logic got_err,
                              input logic exp_err, input int got_cyc, input int exp_cyc);
        if (got_err !== exp_err) begin
            resp_errors++;
            $display("error: pslverr got %h expected %h at paddr %h", got_err, exp_err, addr);
        end
        if (got_cyc != exp_cyc) begin
            resp_errors++;
            $display("transfer to address %h took %0d access cycles instead of %0d",
                     addr, got_cyc, exp_cyc);
        end
    endtask

    // one APB transfer, the response is sampled in each access cycle before the rising edge
    task automatic apb_xfer(input logic wr, input logic [`RV_APB_AW-1:0] addr,
                            input logic [`RV_XLEN-1:0] wdata,
                            output logic [`RV_XLEN-1:0] rdata, output logic err,
                            output int cycles);
        logic done;
        done   = 1'b0;
        rdata  = '0;
        err    = 1'b0;
        cycles = 0;
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        while (!done) begin
            #(SAMPLE_DELAY);
            cycles++;
            if (pready) begin
                done  = 1'b1;
                err   = pslverr;
                rdata = prdata;
            end else if (cycles >= MAX_WAIT) begin
                done = 1'b1;
                handshake_errors++;
                $display("no pready within %0d access cycles at address %h", MAX_WAIT, addr);
            end
            @(negedge clk);
        end
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic read_word(input logic [`RV_APB_AW-1:0] addr,
                             output logic [`RV_XLEN-1:0] data);
        logic err;
        int   cyc;
        apb_xfer(1'b0, addr, '0, data, err, cyc);
        check_resp(addr, err, 1'b0, cyc, 1);
    endtask

    task automatic read_reg(input int idx, output logic [`RV_XLEN-1:0] data);
        read_word(`RV_ADDR_REG_BASE + 8'(4 * idx), data);
    endtask

    // ISA rules for the kept instructions, applied to the model state
    task automatic model_exec(input logic [31:0] w);
        logic [6:0]  opc;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        logic [31:0] imm_i;
        logic [31:0] imm_b;
        logic        taken;
        opc   = w[6:0];
        rd    = w[11:7];
        f3    = w[14:12];
        a     = m_regs[w[19:15]];
        b     = m_regs[w[24:20]];
        imm_i = {{20{w[31]}}, w[31:20]};
        imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        r     = '0;
        taken = 1'b0;
        if (opc == 7'h13) begin
            b = imm_i;
        end
        case (opc)
            7'h33, 7'h13: begin
                case (f3)
                    3'h0: r = (opc == 7'h33 && w[30]) ? a - b : a + b;
                    3'h1: r = a << b[4:0];
                    3'h2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    3'h3: r = (a < b) ? 32'd1 : 32'd0;
                    3'h4: r = a ^ b;
                    3'h5: begin
                        if (w[30]) begin
                            r = $signed(a) >>> b[4:0];
                        end else begin
                            r = a >> b[4:0];
                        end
                    end
                    3'h6: r = a | b;
                    default: r = a & b;
                endcase
            end
            7'h37: r = {w[31:12], 12'h000};
            7'h17: r = m_pc + {w[31:12], 12'h000};
            default: begin
                case (f3)
                    3'h0: taken = (a == b);
                    3'h1: taken = (a != b);
                    3'h4: taken = ($signed(a) < $signed(b));
                    3'h5: taken = !($signed(a) < $signed(b));
                    3'h6: taken = (a < b);
                    default: taken = !(a < b);
                endcase
            end
        endcase
        if (opc != 7'h63 && rd != 5'd0) begin
            m_regs[rd] = r;
        end
        m_pc      = taken ? m_pc + imm_b : m_pc + 32'd4;
        m_retired = m_retired + 16'd1;
        if (taken) begin
            m_taken = m_taken + 16'd1;
        end
    endtask

    task automatic issue_instr(input logic [31:0] w, input logic legal);
        logic [`RV_XLEN-1:0] unused_rdata;
        logic                err;
        int                  cyc;
        apb_xfer(1'b1, `RV_ADDR_INSTR, w, unused_rdata, err, cyc);
        check_resp(`RV_ADDR_INSTR, err, !legal, cyc, legal ? 3 : 1);
        if (legal) begin
            model_exec(w);
            n_legal = n_legal + 16'd1;
        end
    endtask

    function automatic logic [31:0] gen_alu();
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm12;
        rd    = 5'(rand_bits(5));
        rs1   = 5'(rand_bits(5));
        rs2   = 5'(rand_bits(5));
        f3    = 3'(rand_bits(3));
        imm12 = 12'(rand_bits(12));
        f7    = ((f3 == 3'h0 || f3 == 3'h5) && rand_bits(1) == 32'd1) ? 7'h20 : 7'h00;
        if (rand_bits(1) == 32'd1) begin
            return {f7, rs2, rs1, f3, rd, 7'h33};
        end
        if (f3 == 3'h1 || f3 == 3'h5) begin
            imm12 = {f3 == 3'h5 ? f7 : 7'h00, imm12[4:0]};  // shifts keep a legal upper field
        end
        return {imm12, rs1, f3, rd, 7'h13};
    endfunction

    function automatic logic [31:0] gen_branch();
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [12:0] imm;
        rs1 = 5'(rand_bits(5));
        rs2 = (rand_bits(2) == 32'd0) ? rs1 : 5'(rand_bits(5));  // equal operands now and then
        f3  = 3'(rand_bits(3));
        if (f3 == 3'h2 || f3 == 3'h3) begin
            f3 = f3 + 3'h4;
        end
        imm = {12'(rand_bits(12)), 1'b0};
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] gen_illegal();
        logic [31:0] w;
        logic [2:0]  kind;
        w    = rand_bits(32);
        kind = 3'(rand_bits(3));
        case (kind)
            3'd0: w[6:0] = 7'h03;  // load
            3'd1: w[6:0] = 7'h23;  // store
            3'd2: w[6:0] = 7'h6f;  // jal
            3'd3: w[6:0] = 7'h67;  // jalr
            3'd4: w = 32'h0000_0073;
            3'd5: w = 32'h0010_0073;
            3'd6: begin
                w[6:0]   = 7'h63;
                w[14:12] = {2'b01, w[12]};  // branch funct3 2 or 3 does not exist
            end
            default: begin
                case (2'(rand_bits(2)))
                    2'd0: w[6:0] = 7'h00;
                    2'd1: w[6:0] = 7'h0f;
                    2'd2: w[6:0] = 7'h7f;
                    default: w[6:0] = 7'h5b;
                endcase
            end
        endcase
        return w;
    endfunction

    task automatic check_all_regs();
        logic [`RV_XLEN-1:0] d;
        for (int i = 0; i < 32; i++) begin
            read_reg(i, d);
            check_reg(i, d, m_regs[i]);
        end
    endtask

    initial begin
        logic [`RV_XLEN-1:0] d;
        logic [`RV_XLEN-1:0] pc_before;
        logic [4:0]          rd;
        int                  total;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        rst_n   = 1'b0;
        lfsr_state = LFSR_SEED;
        m_pc       = '0;
        m_retired  = '0;
        m_taken    = '0;
        n_legal    = '0;
        for (int i = 0; i < 32; i++) begin
            m_regs[i] = '0;
        end
        reg_errors       = 0;
        pc_errors        = 0;
        count_errors     = 0;
        resp_errors      = 0;
        handshake_errors = 0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        read_word(`RV_ADDR_PC, d);
        check_pc(d, '0);
        read_word(`RV_ADDR_RETIRED, d);
        check_count(d, '0);
        rd = 5'(rand_bits(5));
        read_reg(int'(rd), d);
        check_reg(int'(rd), d, '0);

        // upper immediates first, so the ALU test starts from wide register values
        for (int n = 0; n < NUM_UPPER; n++) begin
            rd        = 5'(rand_bits(5));
            pc_before = m_pc;
            issue_instr({20'(rand_bits(20)), rd, rand_bits(1) == 32'd1 ? 7'h17 : 7'h37}, 1'b1);
            read_reg(int'(rd), d);
            check_reg(int'(rd), d, m_regs[rd]);
            read_word(`RV_ADDR_PC, d);
            check_pc(d, pc_before + 32'd4);
        end

        for (int n = 0; n < NUM_ALU; n++) begin
            issue_instr(gen_alu(), 1'b1);
        end
        check_all_regs();

        for (int n = 0; n < NUM_BRANCH; n++) begin
            issue_instr(gen_branch(), 1'b1);
            read_word(`RV_ADDR_PC, d);
            check_pc(d, m_pc);
        end
        read_word(`RV_ADDR_RETIRED, d);
        check_count(d, {m_taken, m_retired});

        for (int n = 0; n < NUM_ILLEGAL; n++) begin
            issue_instr(gen_illegal(), 1'b0);
            read_word(`RV_ADDR_PC, d);
            check_pc(d, m_pc);
        end
        read_word(`RV_ADDR_RETIRED, d);
        check_count(d, {m_taken, m_retired});
        check_all_regs();

        read_word(`RV_ADDR_RETIRED, d);
        check_count(d, {m_taken, n_legal});

        total = reg_errors + pc_errors + count_errors + resp_errors + handshake_errors;
        $display("error counts: reg %0d, pc %0d, count %0d, response %0d, handshake %0d",
                 reg_errors, pc_errors, count_errors, resp_errors, handshake_errors);
        if (total == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: rtl/core/rv_mike_core.sv
`include "rv_mike_macros.svh"

module rv_mike_core (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [`RV_APB_AW-1:0] paddr,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [`RV_XLEN-1:0]   pwdata,
    output logic [`RV_XLEN-1:0]   prdata,
    output logic                  pready,
    output logic                  pslverr
);

    logic [`RV_XLEN-1:0]  instr;
    logic [`RV_XLEN-1:0]  op_a;
    logic [`RV_XLEN-1:0]  op_b;
    logic [`RV_XLEN-1:0]  alu_result;
    logic                 alu_zero;
    logic                 alu_lt;
    logic                 rd_we;
    logic [`RV_XLEN-1:0]  rd_data;
    logic [`RV_XLEN-1:0]  rs1_data;
    logic [`RV_XLEN-1:0]  rs2_data;
    logic [`RV_REG_W-1:0] rd_sel;
    logic [`RV_XLEN-1:0]  dbg_data;
    logic                 retire;
    logic                 branch_taken;
    logic [`RV_XLEN-1:0]  retired_count;

    exec_ctrl_if ctrl_bus ();

    instr_decoder u_decoder (
        .instr    (instr),
        .ctrl_bus (ctrl_bus.decoder)
    );

    exec_fsm u_fsm (
        .clk           (clk),
        .rst_n         (rst_n),
        .paddr         (paddr),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .pwdata        (pwdata),
        .prdata        (prdata),
        .pready        (pready),
        .pslverr       (pslverr),
        .instr         (instr),
        .ctrl_bus      (ctrl_bus.sequencer),
        .op_a          (op_a),
        .op_b          (op_b),
        .alu_result    (alu_result),
        .alu_zero      (alu_zero),
        .alu_lt        (alu_lt),
        .rd_we         (rd_we),
        .rd_data       (rd_data),
        .rs1_data      (rs1_data),
        .rs2_data      (rs2_data),
        .rd_sel        (rd_sel),
        .dbg_data      (dbg_data),
        .retire        (retire),
        .branch_taken  (branch_taken),
        .retired_count (retired_count)
    );

    alu u_alu (
        .op         (ctrl_bus.ctrl.alu_op),
        .signed_cmp (ctrl_bus.ctrl.alu_signed),
        .a          (op_a),
        .b          (op_b),
        .result     (alu_result),
        .zero       (alu_zero),
        .lt         (alu_lt)
    );

    reg_file u_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1      (ctrl_bus.rs1),
        .rs2      (ctrl_bus.rs2),
        .dbg_sel  (rd_sel),
        .we       (rd_we),
        .rd       (ctrl_bus.rd),
        .wdata    (rd_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .dbg_data (dbg_data)
    );

    retire_counter u_retire (
        .clk           (clk),
        .rst_n         (rst_n),
        .retire        (retire),
        .branch_taken  (branch_taken),
        .retired_count (retired_count)
    );

endmodule

// File: rtl/core/exec_fsm.sv
`include "rv_mike_macros.svh"

module exec_fsm import rv_mike_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [`RV_APB_AW-1:0] paddr,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [`RV_XLEN-1:0]   pwdata,
    output logic [`RV_XLEN-1:0]   prdata,
    output logic                  pready,
    output logic                  pslverr,
    output logic [`RV_XLEN-1:0]   instr,
    exec_ctrl_if.sequencer        ctrl_bus,
    output logic [`RV_XLEN-1:0]   op_a,
    output logic [`RV_XLEN-1:0]   op_b,
    input  logic [`RV_XLEN-1:0]   alu_result,
    input  logic                  alu_zero,
    input  logic                  alu_lt,
    output logic                  rd_we,
    output logic [`RV_XLEN-1:0]   rd_data,
    input  logic [`RV_XLEN-1:0]   rs1_data,
    input  logic [`RV_XLEN-1:0]   rs2_data,
    output logic [`RV_REG_W-1:0]  rd_sel,
    input  logic [`RV_XLEN-1:0]   dbg_data,
    output logic                  retire,
    output logic                  branch_taken,
    input  logic [`RV_XLEN-1:0]   retired_count
);

    exec_state_t         state;
    logic [`RV_XLEN-1:0] pc_q;
    logic [`RV_XLEN-1:0] alu_q;
    logic                taken_q;
    logic                setup;
    logic                access;
    logic                instr_wr;
    logic                branch_hit;

    assign setup    = psel && !penable;
    assign access   = psel && penable;
    assign instr_wr = pwrite && (paddr == `RV_ADDR_INSTR);

    assign op_a = ctrl_bus.ctrl.src_a_pc ? pc_q : rs1_data;  // AUIPC sees the old PC
    assign op_b = ctrl_bus.ctrl.src_b_imm ? ctrl_bus.imm : rs2_data;

    assign branch_hit = ctrl_bus.ctrl.is_branch &&
        ((ctrl_bus.ctrl.branch_on_lt ? alu_lt : alu_zero) ^ ctrl_bus.ctrl.branch_invert);

    assign rd_we        = (state == ST_WRITEBACK) && ctrl_bus.ctrl.reg_write;
    assign rd_data      = alu_q;
    assign retire       = (state == ST_WRITEBACK);
    assign branch_taken = (state == ST_WRITEBACK) && taken_q;
    assign rd_sel       = paddr[2 +: `RV_REG_W];  // register window starts at 0x80

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            pc_q    <= '0;
            instr   <= '0;
            taken_q <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (setup && instr_wr) begin
                        instr <= pwdata;  // decoded during the first access cycle
                    end
                    if (access && instr_wr && ctrl_bus.ctrl.legal) begin
                        state <= ST_EXECUTE;
                    end
                end
                ST_EXECUTE: begin
                    taken_q <= branch_hit;
                    state   <= ST_WRITEBACK;
                end
                default: begin
                    pc_q  <= taken_q ? pc_q + ctrl_bus.imm : pc_q + 32'd4;
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_EXECUTE) begin
            alu_q <= alu_result;
        end
    end

    // only the instruction write inserts wait states
    always_comb begin
        pready  = 1'b0;
        pslverr = 1'b0;
        if (access) begin
            if (!instr_wr) begin
                pready = 1'b1;
            end else if (state == ST_IDLE && !ctrl_bus.ctrl.legal) begin
                pready  = 1'b1;
                pslverr = 1'b1;
            end else begin
                pready = (state == ST_WRITEBACK);
            end
        end
    end

    always_comb begin
        if (paddr[`RV_APB_AW-1]) begin
            prdata = dbg_data;
        end else begin
            case (paddr)
                `RV_ADDR_INSTR:   prdata = instr;
                `RV_ADDR_PC:      prdata = pc_q;
                `RV_ADDR_RETIRED: prdata = retired_count;
                default:          prdata = '0;
            endcase
        end
    end

    a_pready_in_access: assert property (@(posedge clk) disable iff (!rst_n)
        pready |-> (psel && penable));

    a_exec_to_wb: assert property (@(posedge clk) disable iff (!rst_n)
        (state == ST_EXECUTE) |=> (state == ST_WRITEBACK));

endmodule

// File: rtl/core/instr_decoder.sv
`include "rv_mike_macros.svh"

module instr_decoder import rv_mike_pkg::*; (
    input  logic [`RV_XLEN-1:0] instr,
    exec_ctrl_if.decoder        ctrl_bus
);

    localparam logic [6:0] OPC_R     = 7'b0110011;
    localparam logic [6:0] OPC_I     = 7'b0010011;
    localparam logic [6:0] OPC_B     = 7'b1100011;
    localparam logic [6:0] OPC_LUI   = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC = 7'b0010111;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    imm_fmt_t   imm_fmt;

    // control word of an instruction that writes rd from the ALU
    function automatic ctrl_word_t alu_cw(alu_op_t op, logic sgn, logic a_pc, logic b_imm);
        ctrl_word_t c;
        c = '0;
        c.alu_op     = op;
        c.alu_signed = sgn;
        c.src_a_pc   = a_pc;
        c.src_b_imm  = b_imm;
        c.reg_write  = 1'b1;
        c.legal      = 1'b1;
        return c;
    endfunction

    // branches always subtract so that zero is valid, lt comes from the comparator
    function automatic ctrl_word_t br_cw(logic on_lt, logic sgn, logic invert);
        ctrl_word_t c;
        c = '0;
        c.alu_op        = ALU_SUB;
        c.alu_signed    = sgn;
        c.is_branch     = 1'b1;
        c.branch_on_lt  = on_lt;
        c.branch_invert = invert;
        c.legal         = 1'b1;
        return c;
    endfunction

    assign opcode       = instr[`RV_OPCODE_MSB:0];
    assign funct3       = instr[`RV_FUNCT3_LSB +: 3];
    assign funct7       = instr[`RV_FUNCT7_LSB +: 7];
    assign ctrl_bus.rd  = instr[`RV_RD_LSB +: `RV_REG_W];
    assign ctrl_bus.rs1 = instr[`RV_RS1_LSB +: `RV_REG_W];
    assign ctrl_bus.rs2 = instr[`RV_RS2_LSB +: `RV_REG_W];

    // loads, stores, jumps and system opcodes fall into the default
    always_comb begin
        case (opcode)
            OPC_R: begin
                case (funct3)
                    3'h0: ctrl_bus.mnemonic = funct7[5] ? OP_SUB : OP_ADD;
                    3'h1: ctrl_bus.mnemonic = OP_SLL;
                    3'h2: ctrl_bus.mnemonic = OP_SLT;
                    3'h3: ctrl_bus.mnemonic = OP_SLTU;
                    3'h4: ctrl_bus.mnemonic = OP_XOR;
                    3'h5: ctrl_bus.mnemonic = funct7[5] ? OP_SRA : OP_SRL;
                    3'h6: ctrl_bus.mnemonic = OP_OR;
                    default: ctrl_bus.mnemonic = OP_AND;
                endcase
            end
            OPC_I: begin
                case (funct3)
                    3'h0: ctrl_bus.mnemonic = OP_ADDI;
                    3'h1: ctrl_bus.mnemonic = OP_SLLI;
                    3'h2: ctrl_bus.mnemonic = OP_SLTI;
                    3'h3: ctrl_bus.mnemonic = OP_SLTIU;
                    3'h4: ctrl_bus.mnemonic = OP_XORI;
                    3'h5: ctrl_bus.mnemonic = funct7[5] ? OP_SRAI : OP_SRLI;
                    3'h6: ctrl_bus.mnemonic = OP_ORI;
                    default: ctrl_bus.mnemonic = OP_ANDI;
                endcase
            end
            OPC_B: begin
                case (funct3)
                    3'h0: ctrl_bus.mnemonic = OP_BEQ;
                    3'h1: ctrl_bus.mnemonic = OP_BNE;
                    3'h4: ctrl_bus.mnemonic = OP_BLT;
                    3'h5: ctrl_bus.mnemonic = OP_BGE;
                    3'h6: ctrl_bus.mnemonic = OP_BLTU;
                    3'h7: ctrl_bus.mnemonic = OP_BGEU;
                    default: ctrl_bus.mnemonic = OP_NA;
                endcase
            end
            OPC_LUI:   ctrl_bus.mnemonic = OP_LUI;
            OPC_AUIPC: ctrl_bus.mnemonic = OP_AUIPC;
            default:   ctrl_bus.mnemonic = OP_NA;
        endcase
    end

    always_comb begin
        case (ctrl_bus.mnemonic)
            OP_ADD:   ctrl_bus.ctrl = alu_cw(ALU_ADD, 1'b0, 1'b0, 1'b0);
            OP_SUB:   ctrl_bus.ctrl = alu_cw(ALU_SUB, 1'b0, 1'b0, 1'b0);
            OP_SLL:   ctrl_bus.ctrl = alu_cw(ALU_SLL, 1'b0, 1'b0, 1'b0);
            OP_SLT:   ctrl_bus.ctrl = alu_cw(ALU_SLT, 1'b1, 1'b0, 1'b0);
            OP_SLTU:  ctrl_bus.ctrl = alu_cw(ALU_SLT, 1'b0, 1'b0, 1'b0);
            OP_XOR:   ctrl_bus.ctrl = alu_cw(ALU_XOR, 1'b0, 1'b0, 1'b0);
            OP_SRL:   ctrl_bus.ctrl = alu_cw(ALU_SRL, 1'b0, 1'b0, 1'b0);
            OP_SRA:   ctrl_bus.ctrl = alu_cw(ALU_SRA, 1'b0, 1'b0, 1'b0);
            OP_OR:    ctrl_bus.ctrl = alu_cw(ALU_OR, 1'b0, 1'b0, 1'b0);
            OP_AND:   ctrl_bus.ctrl = alu_cw(ALU_AND, 1'b0, 1'b0, 1'b0);
            OP_ADDI:  ctrl_bus.ctrl = alu_cw(ALU_ADD, 1'b0, 1'b0, 1'b1);
            OP_SLLI:  ctrl_bus.ctrl = alu_cw(ALU_SLL, 1'b0, 1'b0, 1'b1);
            OP_SLTI:  ctrl_bus.ctrl = alu_cw(ALU_SLT, 1'b1, 1'b0, 1'b1);
            OP_SLTIU: ctrl_bus.ctrl = alu_cw(ALU_SLT, 1'b0, 1'b0, 1'b1);
            OP_XORI:  ctrl_bus.ctrl = alu_cw(ALU_XOR, 1'b0, 1'b0, 1'b1);
            OP_SRLI:  ctrl_bus.ctrl = alu_cw(ALU_SRL, 1'b0, 1'b0, 1'b1);
            OP_SRAI:  ctrl_bus.ctrl = alu_cw(ALU_SRA, 1'b0, 1'b0, 1'b1);
            OP_ORI:   ctrl_bus.ctrl = alu_cw(ALU_OR, 1'b0, 1'b0, 1'b1);
            OP_ANDI:  ctrl_bus.ctrl = alu_cw(ALU_AND, 1'b0, 1'b0, 1'b1);
            OP_LUI:   ctrl_bus.ctrl = alu_cw(ALU_PASS_B, 1'b0, 1'b0, 1'b1);
            OP_AUIPC: ctrl_bus.ctrl = alu_cw(ALU_ADD, 1'b0, 1'b1, 1'b1);
            OP_BEQ:   ctrl_bus.ctrl = br_cw(1'b0, 1'b0, 1'b0);
            OP_BNE:   ctrl_bus.ctrl = br_cw(1'b0, 1'b0, 1'b1);
            OP_BLT:   ctrl_bus.ctrl = br_cw(1'b1, 1'b1, 1'b0);
            OP_BGE:   ctrl_bus.ctrl = br_cw(1'b1, 1'b1, 1'b1);
            OP_BLTU:  ctrl_bus.ctrl = br_cw(1'b1, 1'b0, 1'b0);
            OP_BGEU:  ctrl_bus.ctrl = br_cw(1'b1, 1'b0, 1'b1);
            default:  ctrl_bus.ctrl = '0;  // legal stays low, the host gets pslverr
        endcase
    end

    always_comb begin
        case (opcode)
            OPC_B:            imm_fmt = IMM_B;
            OPC_LUI, OPC_AUIPC: imm_fmt = IMM_U;
            default:          imm_fmt = IMM_I;  // R-type ignores it
        endcase
    end

    always_comb begin
        case (imm_fmt)
            IMM_U:   ctrl_bus.imm = {instr[31:12], 12'b0};
            IMM_B:   ctrl_bus.imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            default: ctrl_bus.imm = {{20{instr[31]}}, instr[31:20]};
        endcase
    end

    // only the ALU and upper-immediate opcodes may write rd
    always_comb begin
        assert (!ctrl_bus.ctrl.reg_write || opcode inside {OPC_R, OPC_I, OPC_LUI, OPC_AUIPC})
            else $error("rejected instruction requests a register write");
    end

endmodule

// File: rtl/retire_counter.sv
`include "rv_mike_macros.svh"

module retire_counter (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                retire,
    input  logic                branch_taken,
    output logic [`RV_XLEN-1:0] retired_count
);

    logic [15:0] retire_cnt;
    logic [15:0] taken_cnt;

    // both counts saturate instead of wrapping
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            retire_cnt <= '0;
            taken_cnt  <= '0;
        end else begin
            if (retire && retire_cnt != '1) begin
                retire_cnt <= retire_cnt + 16'd1;
            end
            if (branch_taken && taken_cnt != '1) begin
                taken_cnt <= taken_cnt + 16'd1;
            end
        end
    end

    assign retired_count = {taken_cnt, retire_cnt};

endmodule

// File: rtl/core/reg_file.sv
`include "rv_mike_macros.svh"

module reg_file (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [`RV_REG_W-1:0] rs1,
    input  logic [`RV_REG_W-1:0] rs2,
    input  logic [`RV_REG_W-1:0] dbg_sel,
    input  logic                 we,
    input  logic [`RV_REG_W-1:0] rd,
    input  logic [`RV_XLEN-1:0]  wdata,
    output logic [`RV_XLEN-1:0]  rs1_data,
    output logic [`RV_XLEN-1:0]  rs2_data,
    output logic [`RV_XLEN-1:0]  dbg_data
);

    logic [`RV_XLEN-1:0] regs [1 << `RV_REG_W];

    // x0 is never written, so it keeps its reset value of zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < (1 << `RV_REG_W); i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];
    assign dbg_data = regs[dbg_sel];  // host read port

    a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n)
        (rs1 == '0) |-> (rs1_data == '0));

endmodule

// File: rtl/core/alu.sv
`include "rv_mike_macros.svh"

module alu import rv_mike_pkg::*; (
    input  alu_op_t             op,
    input  logic                signed_cmp,
    input  logic [`RV_XLEN-1:0] a,
    input  logic [`RV_XLEN-1:0] b,
    output logic [`RV_XLEN-1:0] result,
    output logic                zero,
    output logic                lt
);

    logic [4:0] shamt;

    assign shamt = b[4:0];  // upper immediate bits of SRAI are dropped here

    // lt is valid for every op so branches can use it next to the SUB result
    assign lt = signed_cmp ? ($signed(a) < $signed(b)) : (a < b);

    always_comb begin
        case (op)
            ALU_ADD:    result = a + b;
            ALU_SUB:    result = a - b;
            ALU_SLL:    result = a << shamt;
            ALU_SLT:    result = {{(`RV_XLEN-1){1'b0}}, lt};
            ALU_XOR:    result = a ^ b;
            ALU_SRL:    result = a >> shamt;
            ALU_SRA:    result = $signed(a) >>> shamt;
            ALU_OR:     result = a | b;
            ALU_AND:    result = a & b;
            ALU_PASS_B: result = b;
            default:    result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

// File: common/exec_ctrl_if.sv
`include "rv_mike_macros.svh"

interface exec_ctrl_if import rv_mike_pkg::*; ();

    ctrl_word_t              ctrl;
    instr_mnemonic_t         mnemonic;
    logic [`RV_REG_W-1:0]    rs1;
    logic [`RV_REG_W-1:0]    rs2;
    logic [`RV_REG_W-1:0]    rd;
    logic [`RV_XLEN-1:0]     imm;   // already sign extended

    modport decoder (
        output ctrl, mnemonic, rs1, rs2, rd, imm
    );

    modport sequencer (
        input ctrl, mnemonic, rs1, rs2, rd, imm
    );

    modport datapath (
        input ctrl, mnemonic, rs1, rs2, rd, imm
    );

endinterface

// File: common/rv_mike_pkg.sv
package rv_mike_pkg;

    typedef enum logic [31:0] {
        OP_NA,
        OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
        OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
        OP_ADDI, OP_SLLI, OP_SLTI, OP_SLTIU, OP_XORI,
        OP_SRLI, OP_SRAI, OP_ORI, OP_ANDI,
        OP_LUI, OP_AUIPC,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU
    } instr_mnemonic_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,    // signedness comes from alu_signed
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B  // used by LUI
    } alu_op_t;

    typedef enum logic [1:0] {
        IMM_I,
        IMM_U,
        IMM_B
    } imm_fmt_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_EXECUTE,
        ST_WRITEBACK
    } exec_state_t;

    typedef struct packed {
        alu_op_t alu_op;
        logic    alu_signed;     // signed compare for SLT and the lt flag
        logic    src_a_pc;       // operand a is the PC instead of rs1
        logic    src_b_imm;      // operand b is the immediate instead of rs2
        logic    reg_write;
        logic    is_branch;
        logic    branch_on_lt;   // branch tests lt, otherwise zero
        logic    branch_invert;  // BNE, BGE and BGEU take the opposite outcome
        logic    legal;
    } ctrl_word_t;

endpackage

// File: common/rv_mike_macros.svh
`ifndef RV_MIKE_MACROS_SVH
`define RV_MIKE_MACROS_SVH

// datapath widths
`define RV_XLEN 32
`define RV_REG_W 5
`define RV_APB_AW 8

// instruction field positions
`define RV_OPCODE_MSB 6
`define RV_RD_LSB 7
`define RV_FUNCT3_LSB 12
`define RV_RS1_LSB 15
`define RV_RS2_LSB 20
`define RV_FUNCT7_LSB 25

// APB register map, xi sits at RV_ADDR_REG_BASE + 4*i
`define RV_ADDR_INSTR 8'h00
`define RV_ADDR_PC 8'h04
`define RV_ADDR_RETIRED 8'h08
`define RV_ADDR_REG_BASE 8'h80

`endif
